// ==== Bender.yml ====
package:
  name: periph_top

sources:
  - include_dirs:
      - hw
    files:
      - hw/nmi_pkg.sv
      - hw/apb_pkg.sv
      - hw/bus.sv
      - hw/soc_sram.sv
      - hw/natv_timer.sv
      - hw/nmi2apb_bridge.sv
      - hw/apb_gpio.sv
      - hw/periph_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verification/tb_periph_top.sv

// ==== build.f ====
+incdir+hw
hw/nmi_pkg.sv
hw/apb_pkg.sv
hw/bus.sv
hw/soc_sram.sv
hw/natv_timer.sv
hw/nmi2apb_bridge.sv
hw/apb_gpio.sv
hw/periph_top.sv
verification/tb_periph_top.sv

// ==== hw/apb_gpio.sv ====
`timescale 1ns/1ps

`include "soc_mmap_defines.svh"

module apb_gpio (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  apb_pkg::apb_req_t  apb_req_i,
  output apb_pkg::apb_rsp_t  apb_rsp_o,
  input  logic [`GPIO_W-1:0] gpio_i,
  output logic [`GPIO_W-1:0] gpio_o
);

  logic [`GPIO_W-1:0] out_q;
  logic [`GPIO_W-1:0] in_meta_q;
  logic [`GPIO_W-1:0] in_sync_q;
  logic               rd_wait_q;
  logic [31:0]        prdata_q;
  logic [31:0]        rd_val;
  logic               access;

  assign access = apb_req_i.psel & apb_req_i.penable;

  always_comb begin
    case (apb_req_i.paddr)
      `GPIO_OUT: rd_val = {{(32-`GPIO_W){1'b0}}, out_q};
      `GPIO_IN:  rd_val = {{(32-`GPIO_W){1'b0}}, in_sync_q};
      default:   rd_val = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      out_q     <= '0;
      rd_wait_q <= 1'b0;
    end else begin
      // Reads hold one wait state while the value is registered
      rd_wait_q <= access & ~apb_req_i.pwrite & ~rd_wait_q;
      if (access && apb_req_i.pwrite && apb_req_i.pstrb[0] &&
          apb_req_i.paddr == `GPIO_OUT) begin
        out_q <= apb_req_i.pwdata[`GPIO_W-1:0];
      end
    end
  end

  // Two-flop input synchroniser and read data register
  always_ff @(posedge clk_i) begin
    in_meta_q <= gpio_i;
    in_sync_q <= in_meta_q;
    if (access && !rd_wait_q) prdata_q <= rd_val;
  end

  assign apb_rsp_o = '{pready: access & (apb_req_i.pwrite | rd_wait_q), prdata: prdata_q};
  assign gpio_o    = out_q;

endmodule

// ==== hw/apb_pkg.sv ====
package apb_pkg;

  // APB request from the bridge
  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic [3:0]  pstrb;
  } apb_req_t;

  // APB response from the slave
  typedef struct packed {
    logic        pready;
    logic [31:0] prdata;
  } apb_rsp_t;

endpackage

// ==== hw/bus.sv ====
`timescale 1ns/1ps

`include "soc_mmap_defines.svh"

module bus (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  nmi_pkg::nmi_req_t core_req_i,
  output nmi_pkg::nmi_rsp_t core_rsp_o,
  output nmi_pkg::nmi_req_t ram_req_o,
  input  nmi_pkg::nmi_rsp_t ram_rsp_i,
  output nmi_pkg::nmi_req_t natv_req_o,
  input  nmi_pkg::nmi_rsp_t natv_rsp_i,
  output nmi_pkg::nmi_req_t apb_req_o,
  input  nmi_pkg::nmi_rsp_t apb_rsp_i
);

  // Clock and reset only mirror the other targets, the decode is combinational
  logic ram_sel;
  logic natv_sel;
  logic apb_sel;
  logic ram_ack;
  logic natv_ack;
  logic apb_ack;

  assign ram_sel  = core_req_i.addr[31:24] == `SRAM_START;
  assign natv_sel = core_req_i.addr[31:24] == `NATV_IP_START;
  assign apb_sel  = core_req_i.addr[31:24] == `CUST_IP_START;

  // Each target sees the full request, valid only when selected
  always_comb begin
    ram_req_o        = core_req_i;
    ram_req_o.valid  = core_req_i.valid & ram_sel;
    natv_req_o       = core_req_i;
    natv_req_o.valid = core_req_i.valid & natv_sel;
    apb_req_o        = core_req_i;
    apb_req_o.valid  = core_req_i.valid & apb_sel;
  end

  assign ram_ack  = ram_req_o.valid & ram_rsp_i.ready;
  assign natv_ack = natv_req_o.valid & natv_rsp_i.ready;
  assign apb_ack  = apb_req_o.valid & apb_rsp_i.ready;

  // Unmapped addresses select nothing and never see ready
  always_comb begin
    core_rsp_o.ready = ram_ack | natv_ack | apb_ack;
    if (ram_ack) begin
      core_rsp_o.rdata = ram_rsp_i.rdata;
    end else if (natv_ack) begin
      core_rsp_o.rdata = natv_rsp_i.rdata;
    end else if (apb_ack) begin
      core_rsp_o.rdata = apb_rsp_i.rdata;
    end else begin
      core_rsp_o.rdata = '0;
    end
  end

endmodule

// ==== hw/natv_timer.sv ====
`timescale 1ns/1ps

`include "soc_mmap_defines.svh"

module natv_timer (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  nmi_pkg::nmi_req_t req_i,
  output nmi_pkg::nmi_rsp_t rsp_o,
  output logic              irq_o
);

  logic        en_q;
  logic [31:0] cnt_q;
  logic [31:0] cmp_q;
  logic        stat_q;
  logic        ready_q;
  logic [31:0] rdata_q;
  logic        accept;
  logic        wr;
  logic [3:0]  reg_off;
  logic [31:0] rd_val;

  assign accept  = req_i.valid & ~ready_q;
  assign wr      = accept & (|req_i.wstrb);
  assign reg_off = {req_i.addr[3:2], 2'b00};

  always_comb begin
    case (reg_off)
      `TMR_CTRL: rd_val = {31'd0, en_q};
      `TMR_CNT:  rd_val = cnt_q;
      `TMR_CMP:  rd_val = cmp_q;
      `TMR_STAT: rd_val = {31'd0, stat_q};
      default:   rd_val = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      en_q    <= 1'b0;
      cnt_q   <= '0;
      cmp_q   <= '0;
      stat_q  <= 1'b0;
      ready_q <= 1'b0;
    end else begin
      ready_q <= accept;
      if (wr && reg_off == `TMR_CTRL) en_q <= req_i.wdata[0];
      if (wr && reg_off == `TMR_CMP) cmp_q <= req_i.wdata;
      // A software load takes priority over counting
      if (wr && reg_off == `TMR_CNT) begin
        cnt_q <= req_i.wdata;
      end else if (en_q) begin
        cnt_q <= cnt_q + 32'd1;
      end
      // Match wins over a clear in the same cycle
      if (en_q && cnt_q == cmp_q) begin
        stat_q <= 1'b1;
      end else if (wr && reg_off == `TMR_STAT && req_i.wdata[0]) begin
        stat_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) rdata_q <= rd_val;
  end

  assign rsp_o = '{ready: ready_q, rdata: rdata_q};
  assign irq_o = stat_q;

endmodule

// ==== hw/nmi2apb_bridge.sv ====
`timescale 1ns/1ps

module nmi2apb_bridge (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  nmi_pkg::nmi_req_t req_i,
  output nmi_pkg::nmi_rsp_t rsp_o,
  output apb_pkg::apb_req_t apb_req_o,
  input  apb_pkg::apb_rsp_t apb_rsp_i
);

  import apb_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETUP,
    ST_ACCESS
  } state_e;

  state_e      state_q;
  apb_req_t    apb_q;
  logic        ready_q;
  logic [31:0] rdata_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q       <= ST_IDLE;
      apb_q.psel    <= 1'b0;
      apb_q.penable <= 1'b0;
      ready_q       <= 1'b0;
    end else begin
      ready_q <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          // Skip the cycle where the previous ack is still visible
          if (req_i.valid && !ready_q) begin
            state_q      <= ST_SETUP;
            apb_q.psel   <= 1'b1;
            apb_q.pwrite <= |req_i.wstrb;
            apb_q.paddr  <= req_i.addr[11:0];
            apb_q.pwdata <= req_i.wdata;
            apb_q.pstrb  <= req_i.wstrb;
          end
        end
        ST_SETUP: begin
          state_q       <= ST_ACCESS;
          apb_q.penable <= 1'b1;
        end
        ST_ACCESS: begin
          if (apb_rsp_i.pready) begin
            state_q       <= ST_IDLE;
            apb_q.psel    <= 1'b0;
            apb_q.penable <= 1'b0;
            ready_q       <= 1'b1;
            rdata_q       <= apb_rsp_i.prdata;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  assign apb_req_o = apb_q;
  assign rsp_o     = '{ready: ready_q, rdata: rdata_q};

endmodule

// ==== hw/nmi_pkg.sv ====
package nmi_pkg;

  // Native request, a zero wstrb marks a read
  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
  } nmi_req_t;

  // Native response
  typedef struct packed {
    logic        ready;
    logic [31:0] rdata;
  } nmi_rsp_t;

endpackage

// ==== hw/periph_top.sv ====
`timescale 1ns/1ps

`include "soc_mmap_defines.svh"

module periph_top (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  nmi_pkg::nmi_req_t  core_req_i,
  output nmi_pkg::nmi_rsp_t  core_rsp_o,
  input  logic [`GPIO_W-1:0] gpio_i,
  output logic [`GPIO_W-1:0] gpio_o,
  output logic               timer_irq_o
);

  import nmi_pkg::*;
  import apb_pkg::*;

  nmi_req_t ram_req;
  nmi_rsp_t ram_rsp;
  nmi_req_t natv_req;
  nmi_rsp_t natv_rsp;
  nmi_req_t bridge_req;
  nmi_rsp_t bridge_rsp;
  apb_req_t apb_req;
  apb_rsp_t apb_rsp;

  bus u_bus (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .core_req_i (core_req_i),
    .core_rsp_o (core_rsp_o),
    .ram_req_o  (ram_req),
    .ram_rsp_i  (ram_rsp),
    .natv_req_o (natv_req),
    .natv_rsp_i (natv_rsp),
    .apb_req_o  (bridge_req),
    .apb_rsp_i  (bridge_rsp)
  );

  soc_sram u_sram (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (ram_req),
    .rsp_o   (ram_rsp)
  );

  natv_timer u_timer (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (natv_req),
    .rsp_o   (natv_rsp),
    .irq_o   (timer_irq_o)
  );

  nmi2apb_bridge u_bridge (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .req_i     (bridge_req),
    .rsp_o     (bridge_rsp),
    .apb_req_o (apb_req),
    .apb_rsp_i (apb_rsp)
  );

  apb_gpio u_gpio (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .apb_req_i (apb_req),
    .apb_rsp_o (apb_rsp),
    .gpio_i    (gpio_i),
    .gpio_o    (gpio_o)
  );

endmodule

// ==== hw/soc_mmap_defines.svh ====
`ifndef SOC_MMAP_DEFINES_SVH
`define SOC_MMAP_DEFINES_SVH

// Top address byte of each region
`define NATV_IP_START 8'h10
`define CUST_IP_START 8'h20
`define SRAM_START    8'h30

// SRAM word address width, 1024 words
`define SRAM_AW 10

// Timer register byte offsets
`define TMR_CTRL 4'h0
`define TMR_CNT  4'h4
`define TMR_CMP  4'h8
`define TMR_STAT 4'hC

// GPIO register offsets on the APB side
`define GPIO_OUT 12'h000
`define GPIO_IN  12'h004

// Number of GPIO pins
`define GPIO_W 8

`endif

// ==== hw/soc_sram.sv ====
`timescale 1ns/1ps

`include "soc_mmap_defines.svh"

module soc_sram (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  nmi_pkg::nmi_req_t req_i,
  output nmi_pkg::nmi_rsp_t rsp_o
);

  logic [31:0]          mem_q [0:(1 << `SRAM_AW)-1];
  logic [`SRAM_AW-1:0]  word_idx;
  logic                 accept;
  logic                 ready_q;
  logic [31:0]          rdata_q;

  assign word_idx = req_i.addr[`SRAM_AW+1:2];

  // One request gives exactly one ready pulse
  assign accept = req_i.valid & ~ready_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= accept;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rdata_q <= mem_q[word_idx];
      for (int b = 0; b < 4; b++) begin
        if (req_i.wstrb[b]) begin
          mem_q[word_idx][b*8 +: 8] <= req_i.wdata[b*8 +: 8];
        end
      end
    end
  end

  assign rsp_o = '{ready: ready_q, rdata: rdata_q};

endmodule

// ==== verification/tb_periph_top.sv ====
`timescale 1ns/1ps

`include "soc_mmap_defines.svh"

module tb_periph_top;

  import nmi_pkg::*;

  localparam int          CLK_PERIOD  = 40;
  localparam int          ACK_TIMEOUT = 50;
  localparam logic [31:0] GPIO_MASK   = (32'd1 << `GPIO_W) - 32'd1;

  logic               clk;
  logic               rst_n;
  nmi_req_t           core_req;
  nmi_rsp_t           core_rsp;
  logic [`GPIO_W-1:0] gpio_in;
  logic [`GPIO_W-1:0] gpio_out;
  logic               timer_irq;

  // Reference copy of the SRAM contents and the word indices written
  logic [31:0] sram_model [0:(1 << `SRAM_AW)-1];
  int          sram_addrs [$];

  periph_top u_dut (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .core_req_i  (core_req),
    .core_rsp_o  (core_rsp),
    .gpio_i      (gpio_in),
    .gpio_o      (gpio_out),
    .timer_irq_o (timer_irq)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  function automatic logic [31:0] sram_addr(input int idx);
    return {`SRAM_START, 24'h0} | (32'(idx) << 2);
  endfunction

  function automatic logic [31:0] timer_addr(input logic [3:0] off);
    return {`NATV_IP_START, 20'h0, off};
  endfunction

  function automatic logic [31:0] gpio_addr(input logic [11:0] off);
    return {`CUST_IP_START, 12'h0, off};
  endfunction

  // Bytes with a strobe bit take the new data, the rest keep the old word
  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                              input logic [3:0] strb);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[b*8 +: 8] = data[b*8 +: 8];
    end
    return res;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("CHECK FAILED: %s got 0x%08h expected 0x%08h", name, got, exp);
      $display("Regression failed");
      $fatal(1, "Stopping on first mismatch");
    end
  endtask

  // Sample mid-cycle until the selected target answers
  task automatic await_ack(output logic [31:0] data);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!core_rsp.ready) begin
      cycles++;
      assert (cycles < ACK_TIMEOUT) else begin
        $display("Timed out after %0d cycles waiting for ready at address 0x%08h",
                 ACK_TIMEOUT, core_req.addr);
        $display("Regression failed");
        $fatal(1, "Stopping on handshake timeout");
      end
      @(negedge clk);
    end
    data = core_rsp.rdata;
    // Valid stays up through the acknowledging edge
    @(posedge clk);
    #2;
    core_req.valid = 1'b0;
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    logic [31:0] unused;
    @(posedge clk);
    #2;
    core_req = '{valid: 1'b1, addr: addr, wdata: data, wstrb: strb};
    await_ack(unused);
  endtask

  // Only the bits set in mask are compared
  task automatic bus_read(input logic [31:0] addr, input logic [31:0] exp,
                          input logic [31:0] mask, input string name,
                          output logic [31:0] data);
    @(posedge clk);
    #2;
    core_req = '{valid: 1'b1, addr: addr, wdata: 32'h0, wstrb: 4'h0};
    await_ack(data);
    check_value(name, data & mask, exp & mask);
  endtask

  task automatic test_reset_state();
    check_value("core_rsp_o.ready", 32'(core_rsp.ready), 32'h0);
    check_value("timer_irq_o", 32'(timer_irq), 32'h0);
    check_value("gpio_o", 32'(gpio_out), 32'h0);
  endtask

  task automatic test_sram();
    int          idx;
    logic [31:0] data;
    logic [31:0] rd;
    for (int i = 0; i < 16; i++) begin
      idx  = $urandom % (1 << `SRAM_AW);
      data = $urandom;
      bus_write(sram_addr(idx), data, 4'hF);
      sram_model[idx] = data;
      sram_addrs.push_back(idx);
    end
    // Partial write over bytes 0 and 2 of a word already written
    idx  = sram_addrs[3];
    data = $urandom;
    bus_write(sram_addr(idx), data, 4'b0101);
    sram_model[idx] = merge_bytes(sram_model[idx], data, 4'b0101);
    foreach (sram_addrs[i]) begin
      idx = sram_addrs[i];
      bus_read(sram_addr(idx), sram_model[idx], 32'hFFFF_FFFF, "core_rsp_o.rdata sram", rd);
    end
  endtask

  task automatic test_timer();
    logic [31:0] cnt_init;
    logic [31:0] rd;
    int          polls;
    cnt_init = 32'h100 + ($urandom & 32'hFF);
    bus_write(timer_addr(`TMR_CNT), cnt_init, 4'hF);
    bus_write(timer_addr(`TMR_CMP), cnt_init + 32'd6, 4'hF);
    bus_read(timer_addr(`TMR_CMP), cnt_init + 32'd6, 32'hFFFF_FFFF,
             "core_rsp_o.rdata timer cmp", rd);
    bus_write(timer_addr(`TMR_CTRL), 32'h1, 4'hF);
    // Counter reaches CMP a few cycles after enable
    polls = 0;
    rd    = 32'h0;
    while (rd[0] !== 1'b1) begin
      assert (polls < 20) else begin
        $display("Timer match flag still clear after %0d status reads", polls);
        $display("Regression failed");
        $fatal(1, "Stopping on timer timeout");
      end
      polls++;
      // Only bit 0 of STAT is defined, the rest read as zero
      bus_read(timer_addr(`TMR_STAT), 32'h0, 32'hFFFF_FFFE,
               "core_rsp_o.rdata timer stat", rd);
    end
    check_value("timer_irq_o", 32'(timer_irq), 32'h1);
    // Write one to clear the flag
    bus_write(timer_addr(`TMR_STAT), 32'h1, 4'hF);
    bus_read(timer_addr(`TMR_STAT), 32'h0, 32'h1, "core_rsp_o.rdata timer stat", rd);
    check_value("timer_irq_o", 32'(timer_irq), 32'h0);
  endtask

  task automatic test_gpio();
    logic [31:0] data;
    logic [31:0] rd;
    data = $urandom;
    bus_write(gpio_addr(`GPIO_OUT), data, 4'hF);
    check_value("gpio_o", 32'(gpio_out), data & GPIO_MASK);
    bus_read(gpio_addr(`GPIO_OUT), data & GPIO_MASK, 32'hFFFF_FFFF,
             "core_rsp_o.rdata gpio out", rd);
    data = $urandom;
    @(posedge clk);
    #2;
    gpio_in = data[`GPIO_W-1:0];
    // Longer than the two-flop synchroniser
    repeat (3) @(posedge clk);
    bus_read(gpio_addr(`GPIO_IN), data & GPIO_MASK, 32'hFFFF_FFFF,
             "core_rsp_o.rdata gpio in", rd);
  endtask

  task automatic test_unmapped();
    logic [31:0] rd;
    int          idx;
    @(posedge clk);
    #2;
    core_req = '{valid: 1'b1, addr: 32'h0000_0040, wdata: 32'h0, wstrb: 4'h0};
    for (int i = 0; i < 20; i++) begin
      @(negedge clk);
      check_value("core_rsp_o.ready", 32'(core_rsp.ready), 32'h0);
    end
    @(posedge clk);
    #2;
    core_req.valid = 1'b0;
    // Decoder must still serve mapped targets afterwards
    idx = sram_addrs[0];
    bus_read(sram_addr(idx), sram_model[idx], 32'hFFFF_FFFF, "core_rsp_o.rdata sram", rd);
  endtask

  initial begin
    void'($urandom(32'h22b2));
    rst_n    = 1'b0;
    core_req = '0;
    gpio_in  = '0;
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;
    test_reset_state();
    test_sram();
    test_timer();
    test_gpio();
    test_unmapped();
    $display("Regression passed");
    $finish;
  end

endmodule
